/* logic/mipsSettings.svh */
/* Sizes and reset vector for the single-cycle MIPS core.
   Include wherever these values are needed; the package only holds types. */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ==========================================================================
// memory and register sizing
// ==========================================================================

// data memory word-address width, 128 words
`define MIPS_DADDR_W 7

// architectural register count, r0 included
`define MIPS_NUM_REGS 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* logic/mipsPkg.sv */
/* Shared types for the MIPS core: instruction encodings, ALU operations
   and the control word that the decoder hands to the datapath. */
`default_nettype none

package mipsPkg;

  // ==========================================================================
  // instruction encodings
  // ==========================================================================

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    rtype = 6'h00,
    j     = 6'h02,
    jal   = 6'h03,
    beq   = 6'h04,
    lw    = 6'h23,
    sw    = 6'h2b
  } opcodeT;

  // funct field of R-type, instr[5:0]
  typedef enum logic [5:0] {
    fJr  = 6'h08,
    fAdd = 6'h20,
    fSub = 6'h22,
    fAnd = 6'h24,
    fOr  = 6'h25,
    fSlt = 6'h2a
  } functT;

  // internal ALU operation select
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd7
  } aluOpT;

  // ==========================================================================
  // control word, 12 bits
  // ==========================================================================
  typedef struct packed {
    logic  regDst;     // dest from rd, else rt
    logic  aluSrcImm;  // ALU b from sign-extended imm
    logic  memToReg;   // write back load data
    logic  regWrite;
    logic  memWrite;
    logic  branch;     // beq
    logic  jump;       // j and jal
    logic  link;       // jal, pc+4 into r31
    logic  jumpReg;    // jr
    aluOpT aluOp;
  } ctrlT;

endpackage

`default_nettype wire

/* logic/controlDecoder.sv */
/* Main decoder: turns opcode and funct into the datapath control word,
   ALU operation included. Purely combinational. */
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
  input  mipsPkg::opcodeT opcode,
  input  mipsPkg::functT  funct,
  output mipsPkg::ctrlT   ctrl
);
  import mipsPkg::*;

  // ==========================================================================
  // decode table
  // ==========================================================================
  always_comb begin
    // unknown encodings fall through as a no-op
    ctrl       = '0;
    ctrl.aluOp = aluNone;
    case (opcode)
      rtype: begin
        ctrl.regDst = 1'b1;
        // ALU control folded in here
        case (funct)
          fAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          fSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          fAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          fOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          fSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // jr, target comes straight from rs
          fJr: ctrl.jumpReg = 1'b1;
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      lw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      sw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      // compare via subtract, zero flag decides
      beq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      j: ctrl.jump = 1'b1;
      jal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.aluOp = aluNone;
    endcase
  end

  // at most one PC redirect source per instruction
  always_comb begin
    assert #0 ($onehot0({ctrl.jump, ctrl.branch, ctrl.jumpReg}))
      else $error("decoder drives more than one PC redirect");
  end

endmodule

`default_nettype wire

/* logic/registerFile.sv */
/* General-purpose register file, two combinational reads and one write
   on the rising clock edge. r0 is fixed at zero. */
`timescale 1ns/1ns
`default_nettype none
`include "mipsSettings.svh"

module registerFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        writeEn,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeData,
  output logic [31:0] readDataA,
  output logic [31:0] readDataB
);

  // r1 up to the top, no storage for r0
  logic [31:0] regs [`MIPS_NUM_REGS-1:1];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // reads see last edge's write, giving RAW forwarding for free
  assign readDataA = (readAddrA == 5'd0) ? 32'd0 : regs[readAddrA];
  assign readDataB = (readAddrB == 5'd0) ? 32'd0 : regs[readAddrB];

  // r0 stays zero even the cycle after a write aimed at it
  assert property (@(posedge clk) disable iff (!rst)
    (writeEn && writeAddr == 5'd0) |=>
      ((readAddrA != 5'd0 || readDataA == '0) && (readAddrB != 5'd0 || readDataB == '0)))
    else $error("r0 read back nonzero after write");

endmodule

`default_nettype wire

/* logic/alu.sv */
/* Integer ALU for the core: add, sub, and, or and signed set-less-than.
   The zero flag drives beq. */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  mipsPkg::aluOpT op,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  output logic [31:0]    result,
  output logic           zero
);
  import mipsPkg::*;

  // ==========================================================================
  // operation select
  // ==========================================================================
  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // signed compare, negative operands included
      aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = 32'd0;
    endcase
  end

  // valid for every op, only beq looks at it
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* logic/pcUnit.sv */
/* Program counter and next-PC select. Priority: jr, then j/jal, then a
   taken beq, else sequential. */
`timescale 1ns/1ns
`default_nettype none
`include "mipsSettings.svh"

module pcUnit (
  input  logic          clk,
  input  logic          rst,
  input  mipsPkg::ctrlT ctrl,
  input  logic          aluZero,
  input  logic [31:0]   immExt,
  input  logic [25:0]   jumpField,
  input  logic [31:0]   regTarget,
  output logic [31:0]   pc,
  output logic [31:0]   pcPlus4
);
  import mipsPkg::*;

  logic [31:0] pcReg;
  logic [31:0] pcNext;

  assign pcPlus4 = pcReg + 32'd4;
  assign pc      = pcReg;

  // ==========================================================================
  // next-PC select
  // ==========================================================================
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = regTarget;
    end else if (ctrl.jump) begin
      // pseudo-direct, top nibble from pc+4
      pcNext = {pcPlus4[31:28], jumpField, 2'b00};
    end else if (ctrl.branch && aluZero) begin
      pcNext = pcPlus4 + {immExt[29:0], 2'b00};
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= `MIPS_RESET_PC;
    end else begin
      pcReg <= pcNext;
    end
  end

  // fetch address stays on a word boundary
  assert property (@(posedge clk) disable iff (!rst) pcReg[1:0] == 2'b00)
    else $error("PC lost word alignment");

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
/* Single-cycle MIPS subset core, top level. Fetch, decode, execute,
   memory and write-back all complete within one clock. */
`timescale 1ns/1ns
`default_nettype none
`include "mipsSettings.svh"

module mipsCore (
  input  logic                     clk,
  input  logic                     rst,
  output logic [31:0]              instrAddr,
  input  logic [31:0]              instr,
  output logic [`MIPS_DADDR_W-1:0] dataAddr,
  output logic [31:0]              dataWrite,
  input  logic [31:0]              dataRead,
  output logic                     memWrite,
  output logic [31:0]              wbData,
  output logic                     wbEn
);
  import mipsPkg::*;

  // ==========================================================================
  // instruction fields
  // ==========================================================================
  opcodeT      opcode;
  functT       funct;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [31:0] immExt;

  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = functT'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  // sign extend the 16-bit immediate
  assign immExt = {{16{instr[15]}}, instr[15:0]};

  ctrlT        ctrl;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [4:0]  destReg;

  controlDecoder controlDecoder_i (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // ==========================================================================
  // datapath muxes
  // ==========================================================================

  // destination, jal always lands in r31
  assign destReg = ctrl.link   ? 5'd31 :
                   ctrl.regDst ? rd    : rt;

  assign aluB = ctrl.aluSrcImm ? immExt : rtData;

  // write-back: link address, load data or ALU
  assign wbData = ctrl.link     ? pcPlus4  :
                  ctrl.memToReg ? dataRead : aluResult;

  // no register or memory update while held in reset
  assign wbEn     = ctrl.regWrite & rst;
  assign memWrite = ctrl.memWrite & rst;

  registerFile registerFile_i (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (wbEn),
    .readAddrA (rs),
    .readAddrB (rt),
    .writeAddr (destReg),
    .writeData (wbData),
    .readDataA (rsData),
    .readDataB (rtData)
  );

  alu alu_i (
    .op     (ctrl.aluOp),
    .a      (rsData),
    .b      (aluB),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit pcUnit_i (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .aluZero   (aluZero),
    .immExt    (immExt),
    .jumpField (instr[25:0]),
    .regTarget (rsData),
    .pc        (pc),
    .pcPlus4   (pcPlus4)
  );

  // ==========================================================================
  // memory ports
  // ==========================================================================
  assign instrAddr = pc;
  // word address, drop the byte offset
  assign dataAddr  = aluResult[`MIPS_DADDR_W+1:2];
  assign dataWrite = rtData;

endmodule

`default_nettype wire

/* verif/mipsTbClock.sv */
/* Testbench clock and reset source: 10 ns clock, rst held low for
   16 cycles and released 1 ns after a rising edge. */
`timescale 1ns/1ns
`default_nettype none

module mipsTbClock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release just after the edge, away from the sampling point
  initial begin
    rst = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/mipsRefModel.sv */
/* Instruction-level model of the MIPS subset. Steps one instruction per
   clock and predicts fetch address, register write-back and stores. */
`timescale 1ns/1ns
`default_nettype none
`include "mipsSettings.svh"

module mipsRefModel (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              instr,
  input  logic [31:0]              initMem [0:(1<<`MIPS_DADDR_W)-1],
  output logic [31:0]              pc,
  output logic                     wbEn,
  output logic [31:0]              wbData,
  output logic                     memWrite,
  output logic [`MIPS_DADDR_W-1:0] dataAddr,
  output logic [31:0]              dataWrite
);

  // ISA encodings, written out from the architecture manual
  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;
  localparam logic [5:0] fnJr    = 6'h08;
  localparam logic [5:0] fnAdd   = 6'h20;
  localparam logic [5:0] fnSub   = 6'h22;
  localparam logic [5:0] fnAnd   = 6'h24;
  localparam logic [5:0] fnOr    = 6'h25;
  localparam logic [5:0] fnSlt   = 6'h2a;

  logic [31:0] regs [0:`MIPS_NUM_REGS-1];
  logic [31:0] mem [0:(1<<`MIPS_DADDR_W)-1];
  logic [31:0] rsVal;
  logic [31:0] rtVal;
  logic [31:0] imm;
  logic [31:0] addr;
  logic [31:0] seqPc;
  logic [31:0] pcNext;
  logic [4:0]  dest;

  // ==========================================================================
  // architectural effect of the current instruction
  // ==========================================================================
  always_comb begin
    // r0 is never written, so it always reads zero
    rsVal     = regs[instr[25:21]];
    rtVal     = regs[instr[20:16]];
    imm       = {{16{instr[15]}}, instr[15:0]};
    addr      = rsVal + imm;
    seqPc     = pc + 32'd4;
    pcNext    = seqPc;
    dest      = 5'd0;
    wbEn      = 1'b0;
    wbData    = 32'd0;
    memWrite  = 1'b0;
    dataAddr  = addr[`MIPS_DADDR_W+1:2];
    dataWrite = rtVal;
    case (instr[31:26])
      opRtype: begin
        dest = instr[15:11];
        wbEn = 1'b1;
        case (instr[5:0])
          fnAdd: wbData = rsVal + rtVal;
          fnSub: wbData = rsVal - rtVal;
          fnAnd: wbData = rsVal & rtVal;
          fnOr:  wbData = rsVal | rtVal;
          fnSlt: wbData = {31'd0, $signed(rsVal) < $signed(rtVal)};
          fnJr: begin
            wbEn   = 1'b0;
            pcNext = rsVal;
          end
          default: wbEn = 1'b0;
        endcase
      end
      opLw: begin
        dest   = instr[20:16];
        wbEn   = 1'b1;
        wbData = mem[dataAddr];
      end
      opSw: memWrite = 1'b1;
      // no delay slot, offset counts from the next word
      opBeq: begin
        if (rsVal == rtVal) pcNext = seqPc + {imm[29:0], 2'b00};
      end
      opJ: pcNext = {seqPc[31:28], instr[25:0], 2'b00};
      opJal: begin
        pcNext = {seqPc[31:28], instr[25:0], 2'b00};
        dest   = 5'd31;
        wbEn   = 1'b1;
        wbData = seqPc;
      end
      default: ;
    endcase
    // nothing retires during reset
    if (!rst) begin
      wbEn     = 1'b0;
      memWrite = 1'b0;
    end
  end

  // ==========================================================================
  // state update
  // ==========================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= 32'd0;
      end
      // same preload as the testbench RAM
      for (int i = 0; i < (1 << `MIPS_DADDR_W); i++) begin
        mem[i] <= initMem[i];
      end
    end else begin
      pc <= pcNext;
      if (wbEn && dest != 5'd0) regs[dest] <= wbData;
      if (memWrite) mem[dataAddr] <= dataWrite;
    end
  end

endmodule

`default_nettype wire

/* verif/mipsTb.sv */
/* Top of the MIPS core simulation. Holds a fixed-program ROM, the data RAM,
   the reference model and per-cycle assertions against it. */
`timescale 1ns/1ns
`default_nettype none
`include "mipsSettings.svh"

module mipsTb;

  localparam int ramWords      = 1 << `MIPS_DADDR_W;
  localparam int progCycles    = 30;
  localparam int timeoutCycles = 3 * progCycles + 16;
  localparam logic [31:0] selfJumpAddr = 32'd116;

  // encodings for the assembler below
  localparam logic [5:0] opLw  = 6'h23;
  localparam logic [5:0] opSw  = 6'h2b;
  localparam logic [5:0] opBeq = 6'h04;
  localparam logic [5:0] opJ   = 6'h02;
  localparam logic [5:0] opJal = 6'h03;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;
  localparam logic [5:0] fnJr  = 6'h08;

  logic                     clk;
  logic                     rst;
  logic [31:0]              instrAddr;
  logic [31:0]              instr;
  logic [`MIPS_DADDR_W-1:0] dataAddr;
  logic [31:0]              dataWrite;
  logic [31:0]              dataRead;
  logic                     memWrite;
  logic [31:0]              wbData;
  logic                     wbEn;
  logic [31:0]              expPc;
  logic                     expWbEn;
  logic [31:0]              expWbData;
  logic                     expMemWrite;
  logic [`MIPS_DADDR_W-1:0] expDataAddr;
  logic [31:0]              expDataWrite;
  logic [31:0]              rom [0:31];
  logic [31:0]              ram [0:ramWords-1];
  logic [31:0]              initWords [0:ramWords-1];
  int                       mismatches = 0;
  int                       resetErrors = 0;
  int                       cycles = 0;

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  mipsTbClock clock_i (
    .clk (clk),
    .rst (rst)
  );

  mipsCore mipsCore_i (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataAddr  (dataAddr),
    .dataWrite (dataWrite),
    .dataRead  (dataRead),
    .memWrite  (memWrite),
    .wbData    (wbData),
    .wbEn      (wbEn)
  );

  mipsRefModel refModel_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (rom[expPc[6:2]]),
    .initMem   (initWords),
    .pc        (expPc),
    .wbEn      (expWbEn),
    .wbData    (expWbData),
    .memWrite  (expMemWrite),
    .dataAddr  (expDataAddr),
    .dataWrite (expDataWrite)
  );

  // ==========================================================================
  // memories
  // ==========================================================================
  assign instr    = rom[instrAddr[6:2]];
  assign dataRead = ram[dataAddr];

  // reloaded every reset cycle and written by stores afterwards
  always @(posedge clk) begin
    if (!rst) begin
      ram <= initWords;
    end else if (memWrite) begin
      ram[dataAddr] <= dataWrite;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  assert property (@(posedge clk) !rst |->
      (instrAddr == `MIPS_RESET_PC && !memWrite && !wbEn))
    else begin
      resetErrors = resetErrors + 1;
      $display("mismatch at %0t: reset state, instrAddr %h memWrite %b wbEn %b", $time,
               $sampled(instrAddr), $sampled(memWrite), $sampled(wbEn));
    end

  assert property (@(posedge clk) disable iff (!rst) instrAddr == expPc)
    else begin
      mismatches = mismatches + 1;
      $display("mismatch at %0t: instrAddr %h, expected %h", $time,
               $sampled(instrAddr), $sampled(expPc));
    end

  assert property (@(posedge clk) disable iff (!rst)
      (wbEn == expWbEn) && (!expWbEn || wbData == expWbData))
    else begin
      mismatches = mismatches + 1;
      $display("mismatch at %0t: wbEn %b wbData %h, expected %b %h", $time,
               $sampled(wbEn), $sampled(wbData), $sampled(expWbEn), $sampled(expWbData));
    end

  // address and data only mean something on a store
  assert property (@(posedge clk) disable iff (!rst) (memWrite == expMemWrite) &&
      (!expMemWrite || (dataAddr == expDataAddr && dataWrite == expDataWrite)))
    else begin
      mismatches = mismatches + 1;
      $display("mismatch at %0t: store %b @%h = %h, expected %b @%h = %h", $time,
               $sampled(memWrite), $sampled(dataAddr), $sampled(dataWrite),
               $sampled(expMemWrite), $sampled(expDataAddr), $sampled(expDataWrite));
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeoutCycles) begin
      $display("timeout: core never reached the final self-jump in %0d cycles", timeoutCycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    void'($urandom(90123));
    for (int i = 0; i < ramWords; i++) begin
      initWords[i] = 32'hD0D0_0000 + i;
    end
    // random operands of opposite sign never compare equal
    initWords[0] = $urandom() & 32'h7FFF_FFFF;
    initWords[1] = $urandom() | 32'h8000_0000;
    initWords[2] = 32'hFFFF_FF00;
    for (int i = 0; i < 32; i++) begin
      rom[i] = 32'd0;
    end
    // a store sits at the reset PC for the first half of reset
    rom[0]  = encodeI(opSw, 5'd0, 5'd0, 16'd0);
    rom[1]  = encodeI(opLw, 5'd0, 5'd2, 16'd4);
    rom[2]  = encodeI(opLw, 5'd0, 5'd3, 16'd8);
    rom[3]  = encodeR(5'd1, 5'd2, 5'd4, fnAdd);
    rom[4]  = encodeR(5'd1, 5'd2, 5'd5, fnSub);
    rom[5]  = encodeR(5'd1, 5'd2, 5'd6, fnAnd);
    rom[6]  = encodeR(5'd1, 5'd2, 5'd7, fnOr);
    // signed slt of negative against positive both ways
    rom[7]  = encodeR(5'd3, 5'd1, 5'd8, fnSlt);
    rom[8]  = encodeR(5'd1, 5'd3, 5'd9, fnSlt);
    rom[9]  = encodeI(opSw, 5'd0, 5'd4, 16'd64);
    rom[10] = encodeI(opSw, 5'd0, 5'd5, 16'd68);
    rom[11] = encodeI(opSw, 5'd0, 5'd8, 16'd72);
    rom[12] = encodeI(opLw, 5'd0, 5'd10, 16'd64);
    rom[13] = encodeI(opLw, 5'd0, 5'd11, 16'd68);
    // write to r0 then store it
    rom[14] = encodeR(5'd1, 5'd2, 5'd0, fnAdd);
    rom[15] = encodeI(opSw, 5'd0, 5'd0, 16'd76);
    // fresh r12 stored straight away
    rom[16] = encodeR(5'd10, 5'd11, 5'd12, fnAdd);
    rom[17] = encodeI(opSw, 5'd0, 5'd12, 16'd80);
    rom[18] = encodeI(opBeq, 5'd1, 5'd2, 16'd5);
    rom[19] = encodeI(opBeq, 5'd10, 5'd4, 16'd1);
    rom[20] = encodeR(5'd1, 5'd1, 5'd13, fnAdd);
    rom[21] = encodeJ(opJ, 26'd23);
    rom[22] = encodeR(5'd1, 5'd1, 5'd14, fnAdd);
    rom[23] = encodeJ(opJal, 26'd26);
    rom[24] = encodeI(opSw, 5'd0, 5'd31, 16'd84);
    rom[25] = encodeJ(opJ, 26'd28);
    // subroutine returning to word 24
    rom[26] = encodeR(5'd2, 5'd3, 5'd15, fnAdd);
    rom[27] = encodeR(5'd31, 5'd0, 5'd0, fnJr);
    rom[28] = encodeI(opLw, 5'd0, 5'd16, 16'd84);
    rom[29] = encodeJ(opJ, 26'd29);

    // second half of reset fetches the first program load
    repeat (8) @(posedge clk);
    #1;
    rom[0] = encodeI(opLw, 5'd0, 5'd1, 16'd0);

    wait (rst);
    while (instrAddr != selfJumpAddr) begin
      @(posedge clk);
    end
    // a few turns around the self-jump
    repeat (4) @(posedge clk);
    #1;
    $display("checks done: %0d mismatches, %0d reset errors", mismatches, resetErrors);
    if (mismatches == 0 && resetErrors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/alu.sv
logic/pcUnit.sv
logic/mipsCore.sv
verif/mipsTbClock.sv
verif/mipsRefModel.sv
verif/mipsTb.sv

/* Makefile */
# Verilator build and run for the single-cycle MIPS core testbench

OBJDIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module mipsTb -f compile.f -Mdir $(OBJDIR)

# the log decides pass or fail, not the simulator's exit code
run: compile
	./$(OBJDIR)/VmipsTb | tee run.log
	grep -q "^Testbench passed$$" run.log

clean:
	rm -rf $(OBJDIR) run.log
